// File: list.f
+incdir+rtl
rtl/fifo_pkg.sv
rtl/fifo_item_counter.sv
rtl/fifo_push_ctrl.sv
rtl/fifo_pop_ctrl.sv
rtl/fifo_ram.sv
rtl/fifo_top.sv
testbench/fifo_sva.sv
testbench/fifo_tb.sv

// File: rtl/fifo_config.svh
// ------------------------------
// FIFO build configuration
// Depth, data width and the
// address and count widths
// ------------------------------

`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// Capacity in items, output stage included
`define FIFO_DEPTH 8

// Data word width in bits
`define FIFO_WIDTH 16

// Derived widths, kept in step with the depth by hand
`define FIFO_ADDR_W 3
`define FIFO_COUNT_W 4

`endif

// File: rtl/fifo_item_counter.sv
// ------------------------------
// FIFO item counter
// Up/down count of stored items
// with next value and empty flag
// ------------------------------

`timescale 1ns/1ps

module fifo_item_counter (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push_beat,
  input  logic             pop_beat,
  output fifo_pkg::count_t items,
  output fifo_pkg::count_t items_next,
  output logic             empty
);

  import fifo_pkg::*;

  // ------------------------------
  // Next count
  // ------------------------------

  // Push and pop in one cycle cancel out
  always_comb begin
    case ({push_beat, pop_beat})
      2'b10:   items_next = items + count_t'(1);
      2'b01:   items_next = items - count_t'(1);
      default: items_next = items;
    endcase
  end

  // ------------------------------
  // Registered count and flag
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      items <= '0;
    end else begin
      items <= items_next;
    end
  end

  // Empty only moves on a beat
  // Starts high since nothing is stored out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      empty <= 1'b1;
    end else if (push_beat || pop_beat) begin
      empty <= (items_next == '0);
    end
  end

endmodule

// File: rtl/fifo_pkg.sv
// ------------------------------
// FIFO package
// Data, address and count types
// Pop state encoding
// ------------------------------

`include "fifo_config.svh"

package fifo_pkg;

  // One stored word
  typedef logic [`FIFO_WIDTH-1:0] data_t;

  // RAM slot index
  typedef logic [`FIFO_ADDR_W-1:0] addr_t;

  // Item count, wide enough for a full buffer
  typedef logic [`FIFO_COUNT_W-1:0] count_t;

  // Pop side states
  // EMPTY  output stage free and RAM drained
  // FETCH  waiting on a RAM read for the output stage
  // VALID  output stage holds a word
  typedef enum logic [1:0] {
    EMPTY = 2'd0,
    FETCH = 2'd1,
    VALID = 2'd2
  } pop_state_t;

endpackage

// File: rtl/fifo_pop_ctrl.sv
// ------------------------------
// FIFO pop controller
// Pop FSM, read pointer, RAM read
// issue and pop output register
// ------------------------------

`timescale 1ns/1ps

`include "fifo_config.svh"

module fifo_pop_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             pop_ready,
  input  logic             push_beat,
  input  fifo_pkg::data_t  push_data,
  input  fifo_pkg::count_t items,
  input  logic             ram_rd_data_valid,
  input  fifo_pkg::data_t  ram_rd_data,
  output logic             pop_valid,
  output fifo_pkg::data_t  pop_data,
  output logic             pop_beat,
  output logic             bypass_ready,
  output logic             ram_rd_addr_valid,
  output fifo_pkg::addr_t  ram_rd_addr
);

  import fifo_pkg::*;

  // Last RAM slot before the pointer wraps
  localparam addr_t LAST_SLOT = addr_t'(`FIFO_DEPTH - 1);

  pop_state_t state;
  pop_state_t state_next;
  addr_t      rd_ptr;
  count_t     ram_words;
  logic       rd_issue;
  logic       load_bypass;
  logic       load_ram;

  // ------------------------------
  // Output stage status
  // ------------------------------

  // Valid straight from the state flop
  assign pop_valid = (state == VALID);
  assign pop_beat  = pop_valid && pop_ready;

  // Bypass only when nothing is stored anywhere
  assign bypass_ready = (state == EMPTY);

  // Unread RAM words while in VALID
  // The count includes the word sitting in the output stage
  // No read is in flight in VALID, so nothing else to subtract
  assign ram_words = items - count_t'(1);

  // ------------------------------
  // State machine
  // ------------------------------

  always_comb begin
    state_next  = state;
    rd_issue    = 1'b0;
    load_bypass = 1'b0;
    load_ram    = 1'b0;
    case (state)
      EMPTY: begin
        // Pushed word goes straight to the output register
        if (push_beat) begin
          load_bypass = 1'b1;
          state_next  = VALID;
        end
      end
      VALID: begin
        if (pop_beat) begin
          if (ram_words != '0) begin
            // Refill read goes out with the pop itself
            rd_issue   = 1'b1;
            state_next = FETCH;
          end else if (push_beat) begin
            // Word lands in RAM at this edge
            // Read it out from FETCH next cycle
            state_next = FETCH;
          end else begin
            state_next = EMPTY;
          end
        end
      end
      FETCH: begin
        if (ram_rd_data_valid) begin
          load_ram   = 1'b1;
          state_next = VALID;
        end else begin
          // No read outstanding yet
          rd_issue = 1'b1;
        end
      end
      default: begin
        state_next = EMPTY;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= EMPTY;
    end else begin
      state <= state_next;
    end
  end

  // ------------------------------
  // RAM read side
  // ------------------------------

  assign ram_rd_addr_valid = rd_issue;
  assign ram_rd_addr       = rd_ptr;

  // Advance on every issued read, wrap at the last slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (rd_issue) begin
      if (rd_ptr == LAST_SLOT) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + addr_t'(1);
      end
    end
  end

  // Output data register
  // Held while the consumer stalls
  always_ff @(posedge clk) begin
    if (load_bypass) begin
      pop_data <= push_data;
    end else if (load_ram) begin
      pop_data <= ram_rd_data;
    end
  end

endmodule

// File: rtl/fifo_push_ctrl.sv
// ------------------------------
// FIFO push controller
// Push ready, write pointer and
// RAM write or bypass steering
// ------------------------------

`timescale 1ns/1ps

`include "fifo_config.svh"

module fifo_push_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push_valid,
  input  fifo_pkg::data_t  push_data,
  input  fifo_pkg::count_t items,
  input  logic             bypass_ready,
  output logic             push_ready,
  output logic             push_beat,
  output logic             ram_wr_valid,
  output fifo_pkg::addr_t  ram_wr_addr,
  output fifo_pkg::data_t  ram_wr_data
);

  import fifo_pkg::*;

  // Last RAM slot before the pointer wraps
  localparam addr_t LAST_SLOT = addr_t'(`FIFO_DEPTH - 1);

  addr_t wr_ptr;
  addr_t wr_ptr_next;

  // ------------------------------
  // Handshake
  // ------------------------------

  // Room left as long as the count is below capacity
  // Independent of the pop side on purpose
  assign push_ready = (items < count_t'(`FIFO_DEPTH));

  // Accepted word this cycle
  assign push_beat = push_valid && push_ready;

  // ------------------------------
  // RAM write steering
  // ------------------------------

  // Pop side takes the word directly while it is idle
  assign ram_wr_valid = push_beat && !bypass_ready;
  assign ram_wr_addr  = wr_ptr;
  assign ram_wr_data  = push_data;

  // Wrap at the last slot
  always_comb begin
    if (wr_ptr == LAST_SLOT) begin
      wr_ptr_next = '0;
    end else begin
      wr_ptr_next = wr_ptr + addr_t'(1);
    end
  end

  // Pointer only moves on a real RAM write
  // Bypassed words never occupy a slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (ram_wr_valid) begin
      wr_ptr <= wr_ptr_next;
    end
  end

endmodule

// File: rtl/fifo_ram.sv
// ------------------------------
// FIFO storage
// Simple dual-port RAM with one
// cycle of registered read
// ------------------------------

`timescale 1ns/1ps

`include "fifo_config.svh"

module fifo_ram (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            ram_wr_valid,
  input  fifo_pkg::addr_t ram_wr_addr,
  input  fifo_pkg::data_t ram_wr_data,
  input  logic            ram_rd_addr_valid,
  input  fifo_pkg::addr_t ram_rd_addr,
  output logic            ram_rd_data_valid,
  output fifo_pkg::data_t ram_rd_data
);

  import fifo_pkg::*;

  data_t mem [`FIFO_DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (ram_wr_valid) begin
      mem[ram_wr_addr] <= ram_wr_data;
    end
  end

  // Read port, data one cycle after the address
  always_ff @(posedge clk) begin
    if (ram_rd_addr_valid) begin
      ram_rd_data <= mem[ram_rd_addr];
    end
  end

  // Strobe lines up with the read data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ram_rd_data_valid <= 1'b0;
    end else begin
      ram_rd_data_valid <= ram_rd_addr_valid;
    end
  end

endmodule

// File: rtl/fifo_top.sv
// ------------------------------
// FIFO top level
// Push and pop controllers, item
// counter and storage RAM
// ------------------------------

`timescale 1ns/1ps

module fifo_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push_valid,
  input  fifo_pkg::data_t  push_data,
  input  logic             pop_ready,
  output logic             push_ready,
  output logic             pop_valid,
  output fifo_pkg::data_t  pop_data,
  output fifo_pkg::count_t items,
  output logic             empty
);

  import fifo_pkg::*;

  // Controller handshakes
  logic   push_beat;
  logic   pop_beat;
  logic   bypass_ready;

  // RAM ports
  logic   ram_wr_valid;
  addr_t  ram_wr_addr;
  data_t  ram_wr_data;
  logic   ram_rd_addr_valid;
  addr_t  ram_rd_addr;
  logic   ram_rd_data_valid;
  data_t  ram_rd_data;

  fifo_push_ctrl i_push_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .items        (items),
    .bypass_ready (bypass_ready),
    .push_ready   (push_ready),
    .push_beat    (push_beat),
    .ram_wr_valid (ram_wr_valid),
    .ram_wr_addr  (ram_wr_addr),
    .ram_wr_data  (ram_wr_data)
  );

  fifo_pop_ctrl i_pop_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .pop_ready         (pop_ready),
    .push_beat         (push_beat),
    .push_data         (push_data),
    .items             (items),
    .ram_rd_data_valid (ram_rd_data_valid),
    .ram_rd_data       (ram_rd_data),
    .pop_valid         (pop_valid),
    .pop_data          (pop_data),
    .pop_beat          (pop_beat),
    .bypass_ready      (bypass_ready),
    .ram_rd_addr_valid (ram_rd_addr_valid),
    .ram_rd_addr       (ram_rd_addr)
  );

  // Shared status flags
  fifo_item_counter i_item_counter (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_beat  (push_beat),
    .pop_beat   (pop_beat),
    .items      (items),
    .items_next (),
    .empty      (empty)
  );

  fifo_ram i_ram (
    .clk               (clk),
    .rst_n             (rst_n),
    .ram_wr_valid      (ram_wr_valid),
    .ram_wr_addr       (ram_wr_addr),
    .ram_wr_data       (ram_wr_data),
    .ram_rd_addr_valid (ram_rd_addr_valid),
    .ram_rd_addr       (ram_rd_addr),
    .ram_rd_data_valid (ram_rd_data_valid),
    .ram_rd_data       (ram_rd_data)
  );

endmodule

// File: testbench/fifo_sva.sv
// ------------------------------
// FIFO assertion module
// Handshake stability, flag rules
// and bypass and refill timing
// ------------------------------

`timescale 1ns/1ps

`include "fifo_config.svh"

module fifo_sva (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 push_valid,
  input logic                 push_ready,
  input fifo_pkg::data_t      push_data,
  input logic                 pop_valid,
  input logic                 pop_ready,
  input fifo_pkg::data_t      pop_data,
  input fifo_pkg::count_t     items,
  input logic                 empty,
  input fifo_pkg::pop_state_t pop_state
);

  import fifo_pkg::*;

  // Bumped on every failed property, watched by the testbench
  int error_count = 0;

  // ------------------------------
  // Flag rules
  // ------------------------------

  // Full buffer is the only reason to refuse a push
  flags_match: assert property (@(posedge clk) disable iff (!rst_n)
    (empty == (items == '0)) && ((!push_ready) == (items == count_t'(`FIFO_DEPTH))))
    else begin
      $error("empty or push_ready disagrees with the item count");
      error_count++;
    end

  // Pop side idles exactly when nothing is stored
  state_match: assert property (@(posedge clk) disable iff (!rst_n)
    (pop_state == EMPTY) == (items == '0))
    else begin
      $error("pop state does not agree with pop_valid or the item count");
      error_count++;
    end

  // ------------------------------
  // Timing rules
  // ------------------------------

  // Push into an empty buffer shows up one cycle later
  bypass_latency: assert property (@(posedge clk) disable iff (!rst_n)
    empty && push_valid && push_ready |=> pop_valid && (pop_data == $past(push_data)))
    else begin
      $error("bypassed word did not reach the output on the next cycle");
      error_count++;
    end

  // Stalled consumer
  pop_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data))
    else begin
      $error("pop output changed while stalled");
      error_count++;
    end

  // One bubble, then the refilled word
  refill_timing: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid && pop_ready && (items >= count_t'(2)) |-> ##1 !pop_valid ##1 pop_valid)
    else begin
      $error("refill after a pop missed its two cycle slot");
      error_count++;
    end

  // Source side rule, guards the stimulus itself
  push_hold: assert property (@(posedge clk) disable iff (!rst_n)
    push_valid && !push_ready |=> push_valid && $stable(push_data))
    else begin
      $error("push source dropped or changed a waiting word");
      error_count++;
    end

endmodule

bind fifo_top fifo_sva i_fifo_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .push_valid (push_valid),
  .push_ready (push_ready),
  .push_data  (push_data),
  .pop_valid  (pop_valid),
  .pop_ready  (pop_ready),
  .pop_data   (pop_data),
  .items      (items),
  .empty      (empty),
  .pop_state  (i_pop_ctrl.state)
);

// File: testbench/fifo_tb.sv
// ------------------------------
// FIFO testbench
// Clock, reset, stimulus, queue
// model checks and watchdog
// ------------------------------

`timescale 1ns/1ps

`include "fifo_config.svh"

module fifo_tb;

  import fifo_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int RANDOM_PUSHES = 300;
  // Bypass word, fill plus the extra word, random traffic
  localparam int TRANSFERS = 1 + `FIFO_DEPTH + 1 + RANDOM_PUSHES;
  localparam int LIMIT_NS = (TRANSFERS * 20 + RESET_CYCLES) * 10;

  logic   clk = 1'b0;
  logic   rst_n;
  logic   push_valid;
  data_t  push_data;
  logic   pop_ready;
  logic   push_ready;
  logic   pop_valid;
  data_t  pop_data;
  count_t items;
  logic   empty;

  // Reference contents, oldest word at the front
  data_t       model_q[$];
  data_t       front_word;
  string       test_name;
  logic        pushes_done;

  fifo_top i_fifo_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_data  (push_data),
    .pop_ready  (pop_ready),
    .push_ready (push_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .items      (items),
    .empty      (empty)
  );

  always #5 clk = ~clk;

  // ------------------------------
  // Failure reporting
  // ------------------------------

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED: test %s, %s expected %0h actual %0h",
               test_name, what, expected, actual);
      stop_with_failure();
    end
  endtask

  // Bound assertions count their failures
  always @(i_fifo_top.i_fifo_sva.error_count) begin
    if (i_fifo_top.i_fifo_sva.error_count != 0) begin
      $display("A bound assertion failed in test %s", test_name);
      stop_with_failure();
    end
  end

  initial begin
    #(LIMIT_NS);
    $display("Watchdog expired, the run hung in test %s", test_name);
    stop_with_failure();
  end

  // ------------------------------
  // Model and scoreboard
  // ------------------------------

  // Pre-edge values, model counts beats up to the last edge
  always @(posedge clk) begin
    if (rst_n) begin
      check_equal("item count", model_q.size(), items);
      check_equal("empty flag", (model_q.size() == 0), empty);
      check_equal("push ready", (model_q.size() < `FIFO_DEPTH), push_ready);
      if (pop_valid && pop_ready) begin
        assert (model_q.size() != 0) else begin
          $display("Pop beat in test %s with nothing pushed", test_name);
          stop_with_failure();
        end
        front_word = model_q.pop_front();
        check_equal("pop data", front_word, pop_data);
      end
      if (push_valid && push_ready) begin
        model_q.push_back(push_data);
      end
    end
  end

  // ------------------------------
  // Stimulus tasks
  // ------------------------------

  // Called on a falling edge, returns on the falling edge after the beat
  task automatic push_word(input data_t value, input int unsigned gap);
    repeat (gap) @(negedge clk);
    push_valid = 1'b1;
    push_data  = value;
    // Ready is stable between edges
    while (!push_ready) @(negedge clk);
    @(negedge clk);
    push_valid = 1'b0;
  endtask

  task automatic wait_drained();
    do @(negedge clk); while (model_q.size() != 0);
  endtask

  initial begin
    void'($urandom(92));
    rst_n       = 1'b0;
    push_valid  = 1'b0;
    push_data   = '0;
    pop_ready   = 1'b0;
    pushes_done = 1'b0;
    test_name   = "reset";
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Reset state
    check_equal("push_ready", 1, push_ready);
    check_equal("empty", 1, empty);
    check_equal("pop_valid", 0, pop_valid);
    check_equal("items", 0, items);

    // Single word through the bypass
    test_name = "bypass";
    push_word(16'h5a3c, 0);
    check_equal("pop_valid", 1, pop_valid);
    check_equal("pop_data", 16'h5a3c, pop_data);
    pop_ready = 1'b1;
    wait_drained();
    pop_ready = 1'b0;

    // Fill with the consumer stalled
    test_name = "fill";
    for (int i = 0; i < `FIFO_DEPTH; i++) begin
      push_word(data_t'(16'h1000 + i), 0);
    end
    check_equal("items when full", `FIFO_DEPTH, items);
    // Full buffer refuses a push even while popping
    push_valid = 1'b1;
    push_data  = 16'hbeef;
    pop_ready  = 1'b1;
    check_equal("push_ready when full", 0, push_ready);
    @(negedge clk);
    pop_ready = 1'b0;
    while (!push_ready) @(negedge clk);
    @(negedge clk);
    push_valid = 1'b0;
    check_equal("items after refill", `FIFO_DEPTH, items);

    test_name = "drain";
    pop_ready = 1'b1;
    wait_drained();
    pop_ready = 1'b0;

    // Random traffic, pop rate swaps between slow and fast phases
    test_name = "random";
    fork
      begin
        for (int i = 0; i < RANDOM_PUSHES; i++) begin
          push_word(data_t'($urandom), $urandom_range(2, 0));
        end
        pushes_done = 1'b1;
      end
      begin
        for (int cyc = 0; !pushes_done || model_q.size() != 0; cyc++) begin
          @(negedge clk);
          pop_ready = ($urandom % 8) < (((cyc / 64) % 2 == 1) ? 2 : 6);
        end
        pop_ready = 1'b0;
      end
    join

    if (i_fifo_top.i_fifo_sva.error_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Bound assertion failures were counted");
      stop_with_failure();
    end
  end

endmodule
